//--- common/m2c_consts.svh
/*
 * Bridge constants: bus widths, lane geometry, burst limits and
 * the depth of the outstanding-response bookkeeping.
 */
`ifndef M2C_CONSTS_SVH
`define M2C_CONSTS_SVH

`define M2C_UNIT_WIDTH      32
`define M2C_LANES           4
`define M2C_MEM_DATA_WIDTH  128
`define M2C_MEM_ADDR_WIDTH  32
`define M2C_CSR_ADDR_WIDTH  16
`define M2C_ID_WIDTH        4
`define M2C_MAX_LENGTH      4
`define M2C_COUNT_WIDTH     5   // up to 16 units per burst
`define M2C_LANE_WIDTH      2
`define M2C_NP_DEPTH        2

`endif

//--- common/m2c_bus_pkg.sv
/*
 * Memory-bus and CSR-bus types: command and response kinds,
 * data words, byte enables, addresses and IDs.
 */
`include "m2c_consts.svh"

package m2c_bus_pkg;

  typedef enum logic [1:0] {
    M2C_READ     = 2'b00,
    M2C_WRITE    = 2'b01,  // posted
    M2C_WRITE_NP = 2'b10
  } m2c_cmd_e;

  typedef enum logic [1:0] {
    M2C_CSR_READ     = 2'b00,
    M2C_CSR_WRITE    = 2'b01,
    M2C_CSR_WRITE_NP = 2'b10
  } m2c_csr_cmd_e;

  typedef enum logic {
    M2C_RESP      = 1'b0,
    M2C_RESP_DATA = 1'b1
  } m2c_resp_e;

  typedef logic [`M2C_MEM_DATA_WIDTH-1:0]   m2c_mem_data_t;
  typedef logic [`M2C_MEM_DATA_WIDTH/8-1:0] m2c_byteen_t;
  typedef logic [`M2C_UNIT_WIDTH-1:0]       m2c_unit_t;
  typedef logic [`M2C_CSR_ADDR_WIDTH-1:0]   m2c_csr_addr_t;
  typedef logic [`M2C_ID_WIDTH-1:0]         m2c_id_t;

endpackage

//--- common/m2c_track_pkg.sv
/*
 * Bookkeeping types for outstanding responses: unit counts,
 * lane indices and the per-burst response info.
 */
`include "m2c_consts.svh"

package m2c_track_pkg;

  typedef logic [`M2C_COUNT_WIDTH-1:0] m2c_count_t;
  typedef logic [`M2C_LANE_WIDTH-1:0]  m2c_lane_t;

  // one entry per read or non-posted write burst
  typedef struct packed {
    m2c_bus_pkg::m2c_resp_e sresp;
    m2c_bus_pkg::m2c_id_t   sid;
    m2c_lane_t              start_lane;  // lane of the first unit
  } m2c_resp_info_t;

endpackage

//--- source/m2c_info_fifo.sv
/*
 * Small synchronous circular-buffer FIFO with a typed payload.
 */
`timescale 1ns/1ps
`include "m2c_consts.svh"

module m2c_info_fifo #(
  parameter type T     = logic,
  parameter int  DEPTH = `M2C_NP_DEPTH
) (
  input  logic i_clk,
  input  logic i_rst_n,
  input  logic i_push,
  input  T     i_data,
  input  logic i_pop,
  output logic o_empty,
  output logic o_full,
  output T     o_data
);
  localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  T              mem [DEPTH];
  logic [PW-1:0] wr_ptr;
  logic [PW-1:0] rd_ptr;
  logic [PW:0]   used;

  function automatic logic [PW-1:0] next_ptr(logic [PW-1:0] ptr);
    return (ptr == PW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      used   <= '0;
    end else begin
      if (i_push) wr_ptr <= next_ptr(wr_ptr);
      if (i_pop) rd_ptr <= next_ptr(rd_ptr);
      used <= used + (PW+1)'(i_push) - (PW+1)'(i_pop);
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_push) mem[wr_ptr] <= i_data;
  end

  assign o_empty = used == '0;
  assign o_full  = used == (PW+1)'(DEPTH);
  assign o_data  = mem[rd_ptr];

  a_no_overflow: assert property (@(posedge i_clk) disable iff (!i_rst_n) o_full |-> !i_push);
  a_no_underflow: assert property (@(posedge i_clk) disable iff (!i_rst_n) o_empty |-> !i_pop);

endmodule

//--- request/m2c_unit_counter.sv
/*
 * Unit counter: tracks units remaining, current lane and CSR address
 * for the units after the first one of a burst.
 */
`timescale 1ns/1ps
`include "m2c_consts.svh"

module m2c_unit_counter (
  input  logic                           i_clk,
  input  logic                           i_rst_n,
  input  logic                           i_load,
  input  logic                           i_step,
  input  logic [`M2C_MEM_ADDR_WIDTH-1:0] i_maddr,
  input  m2c_track_pkg::m2c_count_t      i_mlength,
  output m2c_track_pkg::m2c_count_t      o_remaining,
  output m2c_track_pkg::m2c_lane_t       o_lane,
  output m2c_bus_pkg::m2c_csr_addr_t     o_csr_addr
);
  import m2c_bus_pkg::*;
  import m2c_track_pkg::*;

  localparam int OFFSET_LSB = $clog2(`M2C_UNIT_WIDTH / 8);

  m2c_lane_t     start_lane;
  m2c_count_t    units;

  function automatic m2c_csr_addr_t next_addr(m2c_csr_addr_t addr);
    return {addr[`M2C_CSR_ADDR_WIDTH-1:OFFSET_LSB] + 1'b1, OFFSET_LSB'(0)};
  endfunction

  assign start_lane = i_maddr[OFFSET_LSB+:`M2C_LANE_WIDTH];
  assign units      = m2c_count_t'({i_mlength, `M2C_LANE_WIDTH'(0)}) - m2c_count_t'(start_lane);

  // load happens as the first unit completes, so it holds the second unit
  always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_remaining <= '0;
      o_lane      <= '0;
      o_csr_addr  <= '0;
    end else if (i_load) begin
      o_remaining <= units - 1'b1;
      o_lane      <= start_lane + 1'b1;
      o_csr_addr  <= next_addr(i_maddr[`M2C_CSR_ADDR_WIDTH-1:0]);
    end else if (i_step) begin
      o_remaining <= o_remaining - 1'b1;
      o_lane      <= o_lane + 1'b1;  // wraps into next beat
      o_csr_addr  <= next_addr(o_csr_addr);
    end
  end

endmodule

//--- request/m2c_request_sequencer.sv
/*
 * Request sequencer: splits memory-bus bursts into single CSR accesses,
 * skips units without byte enables and steers the command/data accepts.
 */
`timescale 1ns/1ps
`include "m2c_consts.svh"

module m2c_request_sequencer (
  input  logic                          i_clk,
  input  logic                          i_rst_n,
  input  logic                          i_mcmd_valid,
  input  m2c_bus_pkg::m2c_cmd_e         i_mcmd,
  input  m2c_bus_pkg::m2c_id_t          i_mid,
  input  logic [`M2C_MEM_ADDR_WIDTH-1:0] i_maddr,
  input  m2c_track_pkg::m2c_count_t     i_mlength,
  input  logic                          i_mdata_valid,
  input  m2c_bus_pkg::m2c_mem_data_t    i_mdata,
  input  m2c_bus_pkg::m2c_byteen_t      i_mdata_byteen,
  input  logic                          i_csr_scmd_accept,
  input  logic                          i_fifo_full,
  input  m2c_track_pkg::m2c_count_t     i_remaining,
  input  m2c_track_pkg::m2c_lane_t      i_lane,
  input  m2c_bus_pkg::m2c_csr_addr_t    i_csr_addr,
  output logic                          o_load,
  output logic                          o_step,
  output logic                          o_scmd_accept,
  output logic                          o_sdata_accept,
  output logic                          o_csr_mcmd_valid,
  output m2c_bus_pkg::m2c_csr_cmd_e     o_csr_mcmd,
  output m2c_bus_pkg::m2c_csr_addr_t    o_csr_maddr,
  output m2c_bus_pkg::m2c_unit_t        o_csr_mdata,
  output logic                          o_info_push,
  output m2c_track_pkg::m2c_resp_info_t o_info,
  output logic                          o_count_push,
  output m2c_track_pkg::m2c_count_t     o_count
);
  import m2c_bus_pkg::*;
  import m2c_track_pkg::*;

  localparam int UNIT_BYTES = `M2C_UNIT_WIDTH / 8;
  localparam int OFFSET_LSB = $clog2(UNIT_BYTES);

  logic       busy;
  logic       is_read;
  logic       is_posted;
  logic       np_ready;
  logic       unit_last;
  logic       lane_last;
  logic       unit_skip;
  logic       unit_go;
  logic       unit_issue;
  logic       unit_done;
  m2c_lane_t  start_lane;
  m2c_lane_t  cur_lane;
  m2c_count_t cur_remaining;
  m2c_count_t issued;

  always_comb begin
    start_lane = i_maddr[OFFSET_LSB+:`M2C_LANE_WIDTH];
    is_read    = i_mcmd == M2C_READ;
    is_posted  = i_mcmd == M2C_WRITE;
    if (busy) begin
      cur_remaining = i_remaining;
      cur_lane      = i_lane;
      o_csr_maddr   = i_csr_addr;
    end else begin  // first unit straight from the command
      cur_remaining = m2c_count_t'({i_mlength, `M2C_LANE_WIDTH'(0)}) - m2c_count_t'(start_lane);
      cur_lane      = start_lane;
      o_csr_maddr   = i_maddr[`M2C_CSR_ADDR_WIDTH-1:0];
    end
    unit_last = cur_remaining == m2c_count_t'(1);
    lane_last = cur_lane == '1;
    unit_skip = !is_read && (i_mdata_byteen[UNIT_BYTES*cur_lane+:UNIT_BYTES] == '0);
  end

  always_comb begin
    np_ready   = busy || !i_fifo_full;  // info slot taken at the first unit
    unit_go    = i_mcmd_valid && (is_read ? np_ready : i_mdata_valid && (is_posted || np_ready));
    unit_issue = unit_go && !unit_skip && i_csr_scmd_accept;
    unit_done  = unit_go && (unit_skip || i_csr_scmd_accept);

    o_csr_mcmd_valid = unit_go && !unit_skip;
    o_csr_mdata      = i_mdata[`M2C_UNIT_WIDTH*cur_lane+:`M2C_UNIT_WIDTH];
    o_scmd_accept    = unit_done && unit_last;
    o_sdata_accept   = unit_done && !is_read && (lane_last || unit_last);
    o_load           = unit_done && !busy;
    o_step           = unit_done && busy;

    case (i_mcmd)
      M2C_READ:  o_csr_mcmd = M2C_CSR_READ;
      M2C_WRITE: o_csr_mcmd = M2C_CSR_WRITE;
      default:   o_csr_mcmd = M2C_CSR_WRITE_NP;
    endcase

    o_info_push  = unit_done && !busy && !is_posted;
    o_info       = '{sresp: is_read ? M2C_RESP_DATA : M2C_RESP, sid: i_mid, start_lane: start_lane};
    o_count_push = unit_done && unit_last && !is_posted;
    o_count      = issued + m2c_count_t'(unit_issue);  // responses to expect
  end

  always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
      busy   <= 1'b0;
      issued <= '0;
    end else if (unit_done) begin
      busy   <= !unit_last;
      issued <= unit_last ? '0 : o_count;
    end
  end

  a_push_room: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_info_push |-> !i_fifo_full);

endmodule

//--- response/m2c_response_merger.sv
/*
 * Response merger: packs CSR read data into memory-bus beats by lane
 * and folds non-posted write responses into a single response.
 */
`timescale 1ns/1ps
`include "m2c_consts.svh"

module m2c_response_merger (
  input  logic                          i_clk,
  input  logic                          i_rst_n,
  input  m2c_track_pkg::m2c_resp_info_t i_info,
  input  logic                          i_info_empty,
  input  m2c_track_pkg::m2c_count_t     i_count,
  input  logic                          i_count_empty,
  input  logic                          i_csr_sresp_valid,
  input  m2c_bus_pkg::m2c_unit_t        i_csr_sdata,
  input  logic                          i_csr_serror,
  input  logic                          i_mresp_accept,
  output logic                          o_csr_mresp_accept,
  output logic                          o_pop,
  output logic                          o_sresp_valid,
  output m2c_bus_pkg::m2c_resp_e        o_sresp,
  output m2c_bus_pkg::m2c_id_t          o_sid,
  output m2c_bus_pkg::m2c_mem_data_t    o_sdata,
  output logic                          o_serror,
  output logic                          o_sresp_last
);
  import m2c_bus_pkg::*;
  import m2c_track_pkg::*;

  localparam int UW = `M2C_UNIT_WIDTH;

  logic       busy;
  logic       is_read;
  logic       last_resp;
  logic       zero_done;
  logic       emit;
  logic       csr_ack;
  logic       err_q;
  m2c_count_t cnt_q;
  m2c_count_t cnt_next;
  m2c_lane_t  lane_q;
  m2c_lane_t  cur_lane;
  m2c_unit_t  held [`M2C_LANES-1];

  always_comb begin
    cur_lane  = busy ? lane_q : i_info.start_lane;
    cnt_next  = (busy ? cnt_q : '0) + 1'b1;
    is_read   = i_info.sresp == M2C_RESP_DATA;
    last_resp = !i_count_empty && (cnt_next == i_count);
    zero_done = !i_info_empty && !i_count_empty && (i_count == '0);  // all units skipped
    emit      = is_read ? (cur_lane == '1) || last_resp : last_resp;

    o_csr_mresp_accept = !i_info_empty && !zero_done && (is_read || !i_count_empty) &&
                         (!emit || i_mresp_accept);  // writes wait for their count
    csr_ack            = i_csr_sresp_valid && o_csr_mresp_accept;
    o_pop              = (csr_ack && last_resp) || (zero_done && i_mresp_accept);

    o_sresp_valid = (!i_info_empty && i_csr_sresp_valid && emit) || zero_done;
    o_sresp       = i_info.sresp;
    o_sid         = i_info.sid;
    o_serror      = err_q || (!zero_done && i_csr_serror);
    o_sresp_last  = last_resp || zero_done;
  end

  always_comb begin
    for (int i = 0; i < `M2C_LANES - 1; i++) begin
      o_sdata[UW*i+:UW] = (cur_lane == m2c_lane_t'(i)) ? i_csr_sdata : held[i];
    end
    o_sdata[UW*(`M2C_LANES-1)+:UW] = i_csr_sdata;  // lane 3 goes straight out
  end

  always_ff @(posedge i_clk) begin
    if (csr_ack && (cur_lane != '1)) held[cur_lane] <= i_csr_sdata;
  end

  always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
      busy   <= 1'b0;
      cnt_q  <= '0;
      lane_q <= '0;
      err_q  <= 1'b0;
    end else begin
      if (o_pop) busy <= 1'b0;
      else if (csr_ack) busy <= 1'b1;
      if (csr_ack) begin
        cnt_q  <= cnt_next;
        lane_q <= cur_lane + 1'b1;
      end
      // error sticks until a beat carries it out
      if ((o_sresp_valid && i_mresp_accept) || o_pop) err_q <= 1'b0;
      else if (csr_ack) err_q <= o_serror;
    end
  end

  a_resp_has_owner: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_csr_sresp_valid |-> !i_info_empty);

endmodule

//--- source/membus2csr_adapter.sv
/*
 * Memory-bus to CSR-bus bridge top: sequencer, unit counter,
 * response info FIFOs and response merger.
 */
`timescale 1ns/1ps
`include "m2c_consts.svh"

module membus2csr_adapter (
  input  logic                           i_clk,
  input  logic                           i_rst_n,
  input  logic                           i_mcmd_valid,
  input  m2c_bus_pkg::m2c_cmd_e          i_mcmd,
  input  m2c_bus_pkg::m2c_id_t           i_mid,
  input  logic [`M2C_MEM_ADDR_WIDTH-1:0] i_maddr,
  input  m2c_track_pkg::m2c_count_t      i_mlength,
  output logic                           o_scmd_accept,
  input  logic                           i_mdata_valid,
  input  m2c_bus_pkg::m2c_mem_data_t     i_mdata,
  input  m2c_bus_pkg::m2c_byteen_t       i_mdata_byteen,
  output logic                           o_sdata_accept,
  output logic                           o_sresp_valid,
  output m2c_bus_pkg::m2c_resp_e         o_sresp,
  output m2c_bus_pkg::m2c_id_t           o_sid,
  output m2c_bus_pkg::m2c_mem_data_t     o_sdata,
  output logic                           o_serror,
  output logic                           o_sresp_last,
  input  logic                           i_mresp_accept,
  output logic                           o_csr_mcmd_valid,
  output m2c_bus_pkg::m2c_csr_cmd_e      o_csr_mcmd,
  output m2c_bus_pkg::m2c_csr_addr_t     o_csr_maddr,
  output m2c_bus_pkg::m2c_unit_t         o_csr_mdata,
  input  logic                           i_csr_scmd_accept,
  input  logic                           i_csr_sresp_valid,
  input  m2c_bus_pkg::m2c_unit_t         i_csr_sdata,
  input  logic                           i_csr_serror,
  output logic                           o_csr_mresp_accept
);
  import m2c_bus_pkg::*;
  import m2c_track_pkg::*;

  logic           load;
  logic           step;
  logic           info_push;
  logic           info_empty;
  logic           info_full;
  logic           count_push;
  logic           count_empty;
  logic           pop;
  m2c_count_t     remaining;
  m2c_lane_t      lane;
  m2c_csr_addr_t  next_addr;
  m2c_resp_info_t info_in;
  m2c_resp_info_t info_out;
  m2c_count_t     count_in;
  m2c_count_t     count_out;

  m2c_request_sequencer u_sequencer (
    .i_clk, .i_rst_n, .i_mcmd_valid, .i_mcmd, .i_mid, .i_maddr, .i_mlength,
    .i_mdata_valid, .i_mdata, .i_mdata_byteen, .i_csr_scmd_accept,
    .i_fifo_full (info_full), .i_remaining (remaining), .i_lane (lane),
    .i_csr_addr (next_addr), .o_load (load), .o_step (step),
    .o_scmd_accept, .o_sdata_accept, .o_csr_mcmd_valid, .o_csr_mcmd,
    .o_csr_maddr, .o_csr_mdata, .o_info_push (info_push), .o_info (info_in),
    .o_count_push (count_push), .o_count (count_in)
  );

  m2c_unit_counter u_counter (
    .i_clk, .i_rst_n, .i_load (load), .i_step (step), .i_maddr, .i_mlength,
    .o_remaining (remaining), .o_lane (lane), .o_csr_addr (next_addr)
  );

  m2c_info_fifo #(.T (m2c_resp_info_t), .DEPTH (`M2C_NP_DEPTH)) u_info_fifo (
    .i_clk, .i_rst_n, .i_push (info_push), .i_data (info_in), .i_pop (pop),
    .o_empty (info_empty), .o_full (info_full), .o_data (info_out)
  );

  // count FIFO trails the info FIFO, so its full flag never gates a push
  m2c_info_fifo #(.T (m2c_count_t), .DEPTH (`M2C_NP_DEPTH)) u_count_fifo (
    .i_clk, .i_rst_n, .i_push (count_push), .i_data (count_in), .i_pop (pop),
    .o_empty (count_empty), .o_full (), .o_data (count_out)
  );

  m2c_response_merger u_merger (
    .i_clk, .i_rst_n, .i_info (info_out), .i_info_empty (info_empty),
    .i_count (count_out), .i_count_empty (count_empty), .i_csr_sresp_valid,
    .i_csr_sdata, .i_csr_serror, .i_mresp_accept, .o_csr_mresp_accept,
    .o_pop (pop), .o_sresp_valid, .o_sresp, .o_sid, .o_sdata, .o_serror,
    .o_sresp_last
  );

endmodule

//--- bench/tb_membus2csr.sv
/*
 * Testbench for the memory-bus to CSR bridge: CSR target model,
 * reference model of the expected responses, checker and watchdog.
 */
`timescale 1ns/1ps
`include "m2c_consts.svh"

module tb_membus2csr;
  import m2c_bus_pkg::*;
  import m2c_track_pkg::*;

  localparam int CLK_PERIOD   = 100;
  localparam int RESET_CYCLES = 10;
  localparam int NUM_RANDOM   = 10;
  localparam int NUM_TESTS    = 6 + NUM_RANDOM;
  localparam int ERR_BASE     = 'h100;  // target flags errors from here up

  typedef struct packed {
    m2c_resp_e     resp;
    m2c_id_t       id;
    m2c_mem_data_t data;
    m2c_mem_data_t mask;  // lanes inside the burst
    logic          err;
    logic          last;
  } exp_beat_t;

  logic                           i_clk, i_rst_n;
  logic                           i_mcmd_valid, o_scmd_accept;
  m2c_cmd_e                       i_mcmd;
  m2c_id_t                        i_mid, o_sid;
  logic [`M2C_MEM_ADDR_WIDTH-1:0] i_maddr;
  m2c_count_t                     i_mlength;
  logic                           i_mdata_valid, o_sdata_accept;
  m2c_mem_data_t                  i_mdata, o_sdata;
  m2c_byteen_t                    i_mdata_byteen;
  logic                           o_sresp_valid, o_serror, o_sresp_last, i_mresp_accept;
  m2c_resp_e                      o_sresp;
  logic                           o_csr_mcmd_valid, i_csr_scmd_accept;
  m2c_csr_cmd_e                   o_csr_mcmd;
  m2c_csr_addr_t                  o_csr_maddr;
  m2c_unit_t                      o_csr_mdata, i_csr_sdata;
  logic                           i_csr_sresp_valid, i_csr_serror, o_csr_mresp_accept;

  m2c_unit_t     target_mem [64];
  m2c_unit_t     shadow_mem [64];
  m2c_mem_data_t stim_data [`M2C_MAX_LENGTH];
  m2c_byteen_t   stim_be [`M2C_MAX_LENGTH];
  exp_beat_t     exp_q [$];
  m2c_unit_t     rsp_data_q [$];
  logic          rsp_err_q [$];
  int unsigned   rsp_dly_q [$];
  string         cur_test;
  logic          bp_on;
  int fail_count, tests_failed, test_errors;
  int resp_seen, resp_base, resp_expected, csr_seen, csr_base, csr_expected;

  membus2csr_adapter membus2csr_adapter_inst (.*);

  initial begin
    i_clk = 1'b0;
    forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
  end

  function automatic m2c_unit_t fill_word(int idx);
    return 32'h1357_0000 + idx * 32'h0001_0203;
  endfunction

  function automatic m2c_unit_t oob_word(m2c_csr_addr_t a);
    return {16'hbad0, a};  // read data above the CSR array
  endfunction

  // expected response beat, from the burst rules and the shadow array
  function automatic exp_beat_t ref_beat(m2c_cmd_e cmd, m2c_id_t id, logic [31:0] addr,
                                         int len, int beat);
    exp_beat_t   e;
    int          first;
    int          u;
    int          lane;
    logic [31:0] ua;
    e       = '0;
    e.resp  = (cmd == M2C_READ) ? M2C_RESP_DATA : M2C_RESP;
    e.id    = id;
    e.last  = (cmd == M2C_READ) ? (beat == len - 1) : 1'b1;
    first   = addr[3:2];
    for (u = 0; u < 4 * len - first; u++) begin
      lane = (first + u) % 4;
      ua   = {addr[31:2], 2'b00} + 32'(4 * u);
      if (cmd == M2C_READ) begin
        if ((first + u) / 4 == beat) begin
          e.data[32*lane +: 32] = (ua < ERR_BASE) ? shadow_mem[ua[7:2]] : oob_word(ua[15:0]);
          e.mask[32*lane +: 32] = '1;
          e.err = e.err | (ua >= ERR_BASE);
        end
      end else if (stim_be[(first + u) / 4][4*lane +: 4] != '0) begin
        e.err = e.err | (ua >= ERR_BASE);
      end
    end
    return e;
  endfunction

  // updates the shadow array, returns the CSR commands the burst needs
  function automatic int apply_burst(m2c_cmd_e cmd, logic [31:0] addr, int len);
    int          first;
    int          cmds;
    int          u;
    int          lane;
    int          beat;
    logic [31:0] ua;
    first = addr[3:2];
    cmds  = 0;
    for (u = 0; u < 4 * len - first; u++) begin
      beat = (first + u) / 4;
      lane = (first + u) % 4;
      ua   = {addr[31:2], 2'b00} + 32'(4 * u);
      if (cmd == M2C_READ) begin
        cmds++;
      end else if (stim_be[beat][4*lane +: 4] != '0) begin
        cmds++;
        if (ua < ERR_BASE) shadow_mem[ua[7:2]] = stim_data[beat][32*lane +: 32];
      end
    end
    return cmds;
  endfunction

  task automatic count_error();
    fail_count++;
    test_errors++;
  endtask

  task automatic check_data(m2c_mem_data_t exp, m2c_mem_data_t act, m2c_mem_data_t mask);
    if ((exp & mask) !== (act & mask)) begin
      $display("[FAIL] %s data: expected %h, actual %h", cur_test, exp & mask, act & mask);
      count_error();
    end
  endtask

  task automatic check_resp(m2c_resp_e exp, m2c_resp_e act);
    if (exp !== act) begin
      $display("[FAIL] %s resp: expected %s, actual %s", cur_test, exp.name(), act.name());
      count_error();
    end
  endtask

  task automatic check_id(m2c_id_t exp, m2c_id_t act);
    if (exp !== act) begin
      $display("[FAIL] %s id: expected %h, actual %h", cur_test, exp, act);
      count_error();
    end
  endtask

  task automatic check_flag(string what, logic exp, logic act);
    if (exp !== act) begin
      $display("[FAIL] %s %s: expected %b, actual %b", cur_test, what, exp, act);
      count_error();
    end
  endtask

  // sends one command with its data beats, holds each until accepted
  task automatic run_burst(m2c_cmd_e cmd, m2c_id_t id, logic [31:0] addr, int len);
    int beat;
    if (cmd == M2C_READ) begin
      for (beat = 0; beat < len; beat++) exp_q.push_back(ref_beat(cmd, id, addr, len, beat));
      resp_expected += len;
    end else if (cmd == M2C_WRITE_NP) begin
      exp_q.push_back(ref_beat(cmd, id, addr, len, 0));
      resp_expected += 1;
    end
    csr_expected += apply_burst(cmd, addr, len);
    @(posedge i_clk);
    i_mcmd_valid <= 1'b1;
    i_mcmd       <= cmd;
    i_mid        <= id;
    i_maddr      <= addr;
    i_mlength    <= m2c_count_t'(len);
    beat = 0;
    if (cmd != M2C_READ) begin
      i_mdata_valid  <= 1'b1;
      i_mdata        <= stim_data[0];
      i_mdata_byteen <= stim_be[0];
    end
    do begin
      @(posedge i_clk);
      if (o_sdata_accept) begin
        beat++;
        if (beat < len) begin
          i_mdata        <= stim_data[beat];
          i_mdata_byteen <= stim_be[beat];
        end
      end
    end while (!o_scmd_accept);
    i_mcmd_valid  <= 1'b0;
    i_mdata_valid <= 1'b0;
  endtask

  task automatic random_burst(m2c_id_t id);
    m2c_cmd_e    cmd;
    logic [31:0] addr;
    int          len;
    int          b;
    int          l;
    cmd  = m2c_cmd_e'(2'($urandom % 3));
    addr = ($urandom % 80) * 4;
    len  = 1 + $urandom % `M2C_MAX_LENGTH;
    for (b = 0; b < len; b++) begin
      stim_data[b] = {$urandom, $urandom, $urandom, $urandom};
      stim_be[b]   = m2c_byteen_t'($urandom);
      for (l = 0; l < `M2C_LANES; l++) begin
        if ($urandom % 4 == 0) stim_be[b][4*l +: 4] = '0;
      end
    end
    run_burst(cmd, id, addr, len);
  endtask

  task automatic begin_test(string name);
    cur_test      = name;
    test_errors   = 0;
    resp_base     = resp_seen;
    resp_expected = 0;
    csr_base      = csr_seen;
    csr_expected  = 0;
  endtask

  task automatic finish_test();
    while (exp_q.size() != 0) @(posedge i_clk);
    repeat (8) @(posedge i_clk);  // room for stray beats
    if (resp_seen - resp_base != resp_expected) begin
      $display("[FAIL] %s response count: expected %0d, actual %0d", cur_test,
               resp_expected, resp_seen - resp_base);
      count_error();
    end
    if (csr_seen - csr_base != csr_expected) begin
      $display("[FAIL] %s CSR commands: expected %0d, actual %0d", cur_test,
               csr_expected, csr_seen - csr_base);
      count_error();
    end
    if (test_errors == 0) begin
      $display("test %-20s ok, %0d responses", cur_test, resp_expected);
    end else begin
      tests_failed++;
      $display("test %-20s failed with %0d errors", cur_test, test_errors);
    end
  endtask

  // CSR target: writes land at command time, responses in order
  always @(posedge i_clk) begin : csr_target
    m2c_csr_addr_t a;
    if (i_rst_n) begin
      if (i_csr_sresp_valid && o_csr_mresp_accept) begin
        void'(rsp_data_q.pop_front());
        void'(rsp_err_q.pop_front());
        void'(rsp_dly_q.pop_front());
      end
      if (o_csr_mcmd_valid && i_csr_scmd_accept) begin
        csr_seen++;
        a = o_csr_maddr;
        if (o_csr_mcmd != M2C_CSR_READ && a < ERR_BASE) target_mem[a[7:2]] = o_csr_mdata;
        if (o_csr_mcmd != M2C_CSR_WRITE) begin  // posted writes get no response
          rsp_data_q.push_back((a >= ERR_BASE) ? oob_word(a) :
                               (o_csr_mcmd == M2C_CSR_READ) ? target_mem[a[7:2]] : '0);
          rsp_err_q.push_back(a >= ERR_BASE);
          rsp_dly_q.push_back($urandom % 4);
        end
      end
      if (rsp_data_q.size() != 0 && rsp_dly_q[0] == 0) begin
        i_csr_sresp_valid <= 1'b1;
        i_csr_sdata       <= rsp_data_q[0];
        i_csr_serror      <= rsp_err_q[0];
      end else begin
        i_csr_sresp_valid <= 1'b0;
        if (rsp_dly_q.size() != 0) rsp_dly_q[0] = rsp_dly_q[0] - 1;
      end
    end
  end

  always @(posedge i_clk) begin
    i_mresp_accept <= bp_on ? (($urandom % 4) != 0) : 1'b1;  // random low periods
  end

  always @(posedge i_clk) begin : compare_responses
    exp_beat_t e;
    if (i_rst_n && o_sresp_valid && i_mresp_accept) begin
      resp_seen++;
      if (exp_q.size() == 0) begin
        $display("test %s: response beat arrived with nothing outstanding", cur_test);
        count_error();
      end else begin
        e = exp_q.pop_front();
        check_resp(e.resp, o_sresp);
        check_id(e.id, o_sid);
        check_flag("error", e.err, o_serror);
        check_flag("last", e.last, o_sresp_last);
        if (e.resp == M2C_RESP_DATA) check_data(e.data, o_sdata, e.mask);
      end
    end
  end

  initial begin
    #((RESET_CYCLES + NUM_TESTS * 200) * CLK_PERIOD);
    $display("watchdog: tests did not finish within %0d cycles", NUM_TESTS * 200);
    $display("Result: FAILED");
    $finish;
  end

  initial begin
    void'($urandom(32'had24));
    i_rst_n           = 1'b0;
    i_mcmd_valid      = 1'b0;
    i_mcmd            = M2C_READ;
    i_mid             = '0;
    i_maddr           = '0;
    i_mlength         = '0;
    i_mdata_valid     = 1'b0;
    i_mdata           = '0;
    i_mdata_byteen    = '0;
    i_mresp_accept    = 1'b0;
    i_csr_scmd_accept = 1'b0;
    i_csr_sresp_valid = 1'b0;
    i_csr_sdata       = '0;
    i_csr_serror      = 1'b0;
    bp_on             = 1'b0;
    fail_count        = 0;
    tests_failed      = 0;
    resp_seen         = 0;
    csr_seen          = 0;
    for (int i = 0; i < 64; i++) begin
      target_mem[i] = fill_word(i);
      shadow_mem[i] = fill_word(i);
    end
    repeat (RESET_CYCLES) @(posedge i_clk);
    i_rst_n           <= 1'b1;
    i_csr_scmd_accept <= 1'b1;

    begin_test("read_single");
    run_burst(M2C_READ, 4'h3, 32'h40, 1);
    finish_test();

    begin_test("read_len3_lane2");
    run_burst(M2C_READ, 4'h5, 32'h88, 3);
    finish_test();

    begin_test("posted_write_readback");
    stim_data[0] = 128'h0a0a_0a0a_0b0b_0b0b_0c0c_0c0c_0d0d_0d0d;
    stim_data[1] = 128'h1111_2222_3333_4444_5555_6666_7777_8888;
    stim_be[0]   = 16'h0f01;  // lanes 0 and 2
    stim_be[1]   = 16'h8000;  // lane 3 only
    run_burst(M2C_WRITE, 4'h6, 32'h20, 2);
    run_burst(M2C_READ, 4'h7, 32'h20, 2);
    finish_test();

    begin_test("np_write_cross_100");
    stim_data[0] = 128'hfeed_0001_feed_0002_feed_0003_feed_0004;
    stim_data[1] = 128'hfeed_0005_feed_0006_feed_0007_feed_0008;
    stim_be[0]   = '1;
    stim_be[1]   = '1;
    run_burst(M2C_WRITE_NP, 4'h8, 32'hf8, 2);
    finish_test();

    begin_test("np_write_below_100");
    run_burst(M2C_WRITE_NP, 4'h9, 32'h60, 1);
    finish_test();

    begin_test("np_write_all_skipped");
    stim_be[0] = '0;
    stim_be[1] = '0;
    run_burst(M2C_WRITE_NP, 4'ha, 32'h30, 2);
    finish_test();

    bp_on = 1'b1;
    for (int k = 0; k < NUM_RANDOM; k++) begin
      begin_test($sformatf("random_%0d", k));
      repeat (3) random_burst(m2c_id_t'(k));
      finish_test();
    end
    bp_on = 1'b0;

    $display("summary: %0d tests, %0d failed, %0d check errors",
             NUM_TESTS, tests_failed, fail_count);
    if (fail_count == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

//--- membus2csr.f
+incdir+common
common/m2c_bus_pkg.sv
common/m2c_track_pkg.sv
source/m2c_info_fifo.sv
request/m2c_unit_counter.sv
request/m2c_request_sequencer.sv
response/m2c_response_merger.sv
source/membus2csr_adapter.sv
bench/tb_membus2csr.sv

//--- Bender.yml
package:
  name: membus2csr

export_include_dirs:
  - common

sources:
  - files:
      - common/m2c_bus_pkg.sv
      - common/m2c_track_pkg.sv
      - source/m2c_info_fifo.sv
      - request/m2c_unit_counter.sv
      - request/m2c_request_sequencer.sv
      - response/m2c_response_merger.sv
      - source/membus2csr_adapter.sv
  - target: test
    files:
      - bench/tb_membus2csr.sv
